// ==== Makefile ====
TOP = shared_bus_tb

.PHONY: all run lint clean

all: run

obj_dir/$(TOP): shared_bus.f hdl/*.sv testbench/*.sv
	verilator --binary --assert -j 0 --top-module $(TOP) -f shared_bus.f -o $(TOP)

run: obj_dir/$(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall --top-module shared_bus_top \
		hdl/bus_types_pkg.sv hdl/arb_pkg.sv hdl/bus_if.sv \
		hdl/bus_arbiter.sv hdl/bus_mux.sv hdl/bus_memory.sv \
		hdl/shared_bus_top.sv

clean:
	rm -rf obj_dir

// ==== hdl/arb_pkg.sv ====
`default_nettype none

// State encoding of the bus arbiter.
package arb_pkg;

    typedef enum logic {
        ARB_READY = 1'b0, // No transfer running, grant follows requests.
        ARB_BUSY  = 1'b1  // Transfer running, grant frozen until ack.
    } arb_state_t;

endpackage

`default_nettype wire

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

// Fixed-priority arbiter. Lowest requesting index wins.
// Grant is taken at once from idle and held until the slave acknowledges.
module bus_arbiter
    import arb_pkg::*;
#(
    parameter int N_MASTERS = 3
) (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 ack,   // Completion pulse from the slave.
    input  wire logic [N_MASTERS-1:0] req,   // Request levels, one per master.
    output      logic [N_MASTERS-1:0] grant  // One-hot grant, registered.
);

    arb_state_t           state_q;    // Ready or busy.
    logic [N_MASTERS-1:0] prio_grant; // One-hot winner of the current requests.
    logic                 any_req;    // At least one master is asking.

    assign any_req = |req;

    // Priority encoder. Scans from index 0 upwards.
    always_comb begin : prio_enc
        logic found;
        found      = 1'b0;
        prio_grant = '0;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (!found && req[i]) begin
                prio_grant[i] = 1'b1; // First requester found.
                found         = 1'b1; // Mask all higher indices.
            end
        end
    end

    // Ready/busy control.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= ARB_READY;
            grant   <= '0;
        end else begin
            case (state_q)
                ARB_READY: begin
                    grant <= prio_grant; // Follows requests every cycle.
                    if (any_req) begin
                        state_q <= ARB_BUSY;
                    end else begin
                        state_q <= ARB_READY;
                    end
                end
                ARB_BUSY: begin
                    // Grant frozen until the slave finishes.
                    if (ack) begin
                        grant <= prio_grant; // Next winner, or none.
                        if (any_req) begin
                            state_q <= ARB_BUSY;
                        end else begin
                            state_q <= ARB_READY;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// Internal bus between the multiplexer and the memory slave.
interface bus_if
    import bus_types_pkg::*;
();

    bus_cmd_t          cmd;   // Command of the granted master.
    logic              valid; // High while any master holds a grant.
    logic              ack;   // One-cycle completion pulse.
    logic [DATA_W-1:0] rdata; // Read data, valid during ack.

    // Master side, driven by the multiplexer.
    modport requester (
        output cmd,
        output valid,
        input  ack,
        input  rdata
    );

    // Slave side, driven by the memory.
    modport responder (
        input  cmd,
        input  valid,
        output ack,
        output rdata
    );

endinterface

`default_nettype wire

// ==== hdl/bus_memory.sv ====
`timescale 1ns/1ps
`default_nettype none

// Synchronous memory slave with a fixed access latency.
// Accepts a command when idle, answers LATENCY edges later with a one-cycle ack.
module bus_memory
    import bus_types_pkg::*;
#(
    parameter int LATENCY = 2,
    parameter int DEPTH   = 256
) (
    input  wire logic clk,
    input  wire logic reset,
    bus_if.responder  bus   // From the multiplexer.
);

    localparam int CNT_W = (LATENCY > 1) ? $clog2(LATENCY) : 1;

    typedef enum logic [1:0] {
        MEM_IDLE  = 2'd0, // Waiting for valid.
        MEM_COUNT = 2'd1, // Latency countdown.
        MEM_ACK   = 2'd2  // Ack cycle, valid ignored.
    } mem_state_t;

    mem_state_t        state_q;
    logic [CNT_W-1:0]  cnt_q;   // Edges left before the access.
    bus_cmd_t          cmd_q;   // Command captured on acceptance.
    logic [DATA_W-1:0] mem [DEPTH]; // Storage, no initial contents.
    logic [DATA_W-1:0] rdata_q; // Last read word.
    logic              ack_q;

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

    // Sequencer. Idle, count, then ack.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= MEM_IDLE;
            cnt_q   <= '0;
            ack_q   <= 1'b0;
        end else begin
            case (state_q)
                MEM_IDLE: begin
                    if (bus.valid) begin
                        state_q <= MEM_COUNT;
                        cnt_q   <= CNT_W'(LATENCY - 1); // Ack after LATENCY edges.
                    end
                end
                MEM_COUNT: begin
                    if (cnt_q == '0) begin
                        state_q <= MEM_ACK;
                        ack_q   <= 1'b1; // Access done on this edge.
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                MEM_ACK: begin
                    state_q <= MEM_IDLE; // Grant may still be the old one here.
                    ack_q   <= 1'b0;
                end
                default: begin
                    state_q <= MEM_IDLE;
                    ack_q   <= 1'b0;
                end
            endcase
        end
    end

    // Command capture and array access.
    always_ff @(posedge clk) begin
        if (state_q == MEM_IDLE && bus.valid) begin
            cmd_q <= bus.cmd; // Mux output may change after this edge.
        end
        if (state_q == MEM_COUNT && cnt_q == '0) begin
            if (cmd_q.we) begin
                mem[cmd_q.addr] <= cmd_q.wdata;
            end else begin
                rdata_q <= mem[cmd_q.addr]; // Held until the next read.
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/bus_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

// Puts the granted master's command onto the internal bus.
module bus_mux
    import bus_types_pkg::*;
#(
    parameter int N_MASTERS = 3
) (
    input  wire logic [N_MASTERS-1:0]        grant, // One-hot grant.
    input  wire logic [N_MASTERS-1:0]        we,    // Write strobe per master.
    input  wire logic [N_MASTERS*ADDR_W-1:0] addr,  // Addresses, master 0 in the low bits.
    input  wire logic [N_MASTERS*DATA_W-1:0] wdata, // Write data, same packing.
    bus_if.requester                         bus    // Towards the memory.
);

    bus_cmd_t sel_cmd; // Command of the granted master.

    // AND-OR selection over the one-hot grant.
    always_comb begin
        sel_cmd = '0; // Zero command when nobody holds the bus.
        for (int i = 0; i < N_MASTERS; i++) begin
            if (grant[i]) begin
                sel_cmd.we    = we[i];
                sel_cmd.addr  = addr[i*ADDR_W +: ADDR_W];
                sel_cmd.wdata = wdata[i*DATA_W +: DATA_W];
            end
        end
    end

    assign bus.cmd   = sel_cmd;
    assign bus.valid = |grant; // Any grant means a command is pending.

endmodule

`default_nettype wire

// ==== hdl/bus_types_pkg.sv ====
`default_nettype none

// Widths and the command word shared by the bus, the multiplexer and the memory.
package bus_types_pkg;

    parameter int ADDR_W = 8;  // One address per word.
    parameter int DATA_W = 16; // Word width.

    // Command as seen on the internal bus, 25 bits wide.
    typedef struct packed {
        logic              we;    // 1 for write, 0 for read.
        logic [ADDR_W-1:0] addr;  // Word address.
        logic [DATA_W-1:0] wdata; // Write data, ignored on reads.
    } bus_cmd_t;

endpackage

`default_nettype wire

// ==== hdl/shared_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

// Shared bus subsystem.
// N_MASTERS requesters share one memory slave through a priority arbiter.
module shared_bus_top
    import bus_types_pkg::*;
#(
    parameter int N_MASTERS = 3,
    parameter int LATENCY   = 2,
    parameter int DEPTH     = 256
) (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic [N_MASTERS-1:0]        req,   // Request levels.
    input  wire logic [N_MASTERS-1:0]        we,    // Write strobes.
    input  wire logic [N_MASTERS*ADDR_W-1:0] addr,  // Packed addresses.
    input  wire logic [N_MASTERS*DATA_W-1:0] wdata, // Packed write data.
    output      logic [N_MASTERS-1:0]        grant, // One-hot grant.
    output      logic                        ack,   // Transfer done.
    output      logic [DATA_W-1:0]           rdata  // Read data during ack.
);

    logic [N_MASTERS-1:0] grant_w; // Arbiter grant, also drives the mux.

    // Internal bus.
    bus_if i_bus ();

    // Arbitration.
    bus_arbiter #(
        .N_MASTERS (N_MASTERS)
    ) i_bus_arbiter (
        .clk   (clk),
        .reset (reset),
        .ack   (i_bus.ack),
        .req   (req),
        .grant (grant_w)
    );

    // Command selection.
    bus_mux #(
        .N_MASTERS (N_MASTERS)
    ) i_bus_mux (
        .grant (grant_w),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .bus   (i_bus.requester)
    );

    // Slave.
    bus_memory #(
        .LATENCY (LATENCY),
        .DEPTH   (DEPTH)
    ) i_bus_memory (
        .clk   (clk),
        .reset (reset),
        .bus   (i_bus.responder)
    );

    assign grant = grant_w;
    assign ack   = i_bus.ack;   // Seen by all masters.
    assign rdata = i_bus.rdata;

endmodule

`default_nettype wire

// ==== shared_bus.f ====
hdl/bus_types_pkg.sv
hdl/arb_pkg.sv
hdl/bus_if.sv
hdl/bus_arbiter.sv
hdl/bus_mux.sv
hdl/bus_memory.sv
hdl/shared_bus_top.sv
testbench/shared_bus_properties.sv
testbench/shared_bus_tb.sv

// ==== testbench/bus_cases.txt ====
// Columns are request mask, late mask, then we, addr and data for masters 0, 1 and 2.
// Late masters ask once the first grant shows. On reads the data column holds the expected word.
1_0_1_10_a5a5_0_00_0000_0_00_0000
1_0_0_10_a5a5_0_00_0000_0_00_0000
7_0_1_20_1111_1_21_2222_1_22_3333
7_0_0_21_2222_0_22_3333_0_10_a5a5
4_1_0_30_beef_0_00_0000_1_30_beef
2_5_0_40_c0de_1_40_c0de_1_41_0f0f
6_0_0_00_0000_0_41_0f0f_1_10_5a5a
1_0_0_10_5a5a_0_00_0000_0_00_0000
5_0_1_ff_ffff_0_00_0000_0_20_1111
3_0_0_ff_ffff_1_00_0001_0_00_0000
2_4_0_00_0000_0_00_0001_1_01_8000
7_0_0_01_8000_0_30_beef_0_40_c0de
4_0_0_00_0000_0_00_0000_1_55_1234
4_3_1_56_4321_0_55_1234_0_55_1234
1_0_0_56_4321_0_00_0000_0_00_0000
7_0_1_57_aaaa_1_57_bbbb_0_57_bbbb

// ==== testbench/shared_bus_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

// Grant and acknowledge rules of the arbiter, bound into bus_arbiter.
module shared_bus_properties
    import arb_pkg::*;
#(
    parameter int N_MASTERS = 3
) (
    input wire logic                 clk,
    input wire logic                 reset,
    input wire logic                 ack,   // Slave completion pulse.
    input wire logic [N_MASTERS-1:0] req,
    input wire logic [N_MASTERS-1:0] grant,
    input wire logic                 state  // Arbiter state register.
);

    int                   fail_count = 0; // Failed assertions so far.
    logic [N_MASTERS-1:0] grant_prev;     // Grant one edge back.
    logic [N_MASTERS-1:0] req_prev;       // Requests one edge back.
    logic [N_MASTERS-1:0] grant_rise;     // Bits that turned on at the last edge.

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_prev <= '0;
            req_prev   <= '0;
        end else begin
            grant_prev <= grant;
            req_prev   <= req;
        end
    end

    assign grant_rise = grant & ~grant_prev;

    grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
        else begin
            $error("grant has more than one bit set: %b", grant);
            fail_count = fail_count + 1;
        end

    grant_held: assert property (@(posedge clk) disable iff (reset)
        (grant != '0 && !ack) |=> $stable(grant))
        else begin
            $error("grant changed without an acknowledge");
            fail_count = fail_count + 1;
        end

    ack_granted: assert property (@(posedge clk) disable iff (reset) ack |-> grant != '0)
        else begin
            $error("acknowledge while no master holds a grant");
            fail_count = fail_count + 1;
        end

    // New owner asked, and nobody with a lower index asked.
    rise_wins: assert property (@(posedge clk) disable iff (reset)
        (grant_rise != '0) |-> ((grant_rise & ~req_prev) == '0)
                            && (((grant_rise - 1'b1) & req_prev) == '0))
        else begin
            $error("grant %b given against requests %b", grant, req_prev);
            fail_count = fail_count + 1;
        end

    busy_state: assert property (@(posedge clk) disable iff (reset)
        (grant != '0) == (state == ARB_BUSY))
        else begin
            $error("arbiter state does not match grant %b", grant);
            fail_count = fail_count + 1;
        end

endmodule

bind bus_arbiter shared_bus_properties #(
    .N_MASTERS (N_MASTERS)
) i_shared_bus_properties (
    .clk   (clk),
    .reset (reset),
    .ack   (ack),
    .req   (req),
    .grant (grant),
    .state (state_q)
);

`default_nettype wire

// ==== testbench/shared_bus_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

// Testbench for the shared bus subsystem.
// Request groups come from the case file, read data is checked against a local memory model.
module shared_bus_tb
    import bus_types_pkg::*;
();

    localparam int N_MASTERS    = 3;
    localparam int LATENCY      = 2;
    localparam int DEPTH        = 256;
    localparam int CLK_PERIOD   = 100;                     // ns.
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 4;                       // Quiet cycles after reset.
    localparam int MAX_CASES    = 64;
    localparam int FIELD_W      = 4 + ADDR_W + DATA_W;     // we nibble, addr, data.
    localparam int CASE_W       = 8 + N_MASTERS * FIELD_W; // Two mask nibbles first.
    localparam int ACK_LIMIT    = LATENCY + 8;             // Cycles to wait for an ack.

    logic                        clk;
    logic                        reset;
    logic [N_MASTERS-1:0]        req;
    logic [N_MASTERS-1:0]        we;
    logic [N_MASTERS*ADDR_W-1:0] addr;
    logic [N_MASTERS*DATA_W-1:0] wdata;
    logic [N_MASTERS-1:0]        grant;
    logic                        ack;
    logic [DATA_W-1:0]           rdata;

    logic [CASE_W-1:0] cases [MAX_CASES];  // Raw case file lines.
    logic [DATA_W-1:0] ref_mem [DEPTH];    // Expected memory contents.
    logic              cmd_we [N_MASTERS]; // Commands of the current group.
    logic [ADDR_W-1:0] cmd_addr [N_MASTERS];
    logic [DATA_W-1:0] cmd_data [N_MASTERS]; // Write data, or expected read word.
    int                acks_seen [N_MASTERS];
    int                num_cases = 0;
    integer            seed = 32'h4f7e;

    always #(CLK_PERIOD / 2) clk = ~clk;

    shared_bus_top #(
        .N_MASTERS (N_MASTERS),
        .LATENCY   (LATENCY),
        .DEPTH     (DEPTH)
    ) i_shared_bus_top (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .we    (we),
        .addr  (addr),
        .wdata (wdata),
        .grant (grant),
        .ack   (ack),
        .rdata (rdata)
    );

    // Counts every ack pulse for the master holding the grant.
    always @(negedge clk) begin
        if (ack === 1'b1) begin
            for (int i = 0; i < N_MASTERS; i++) begin
                if (grant[i]) begin
                    acks_seen[i]++;
                end
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("MISMATCH at %0t ns: %s expected %0h, got %0h", $time, name, expected,
                     actual);
            $display("TB FAILED");
            $fatal(1, "Value check on %s failed.", name);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("ERROR at %0t ns: %s", $time, reason);
        $display("TB FAILED");
        $fatal(1, "Run stopped.");
    endtask

    // One ns after the next rising edge. Outputs are settled, inputs change here.
    task automatic next_slot();
        @(posedge clk);
        #1;
    endtask

    function automatic logic [N_MASTERS-1:0] lowest_set(input logic [N_MASTERS-1:0] mask);
        return mask & (~mask + 1'b1); // Two's complement trick.
    endfunction

    function automatic int onehot_index(input logic [N_MASTERS-1:0] onehot);
        int idx;
        idx = -1;
        for (int i = 0; i < N_MASTERS; i++) begin
            if (onehot[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            next_slot();
            check_value("grant", 32'd0, 32'(grant)); // Nobody asks.
            check_value("ack", 32'd0, 32'(ack));
        end
    endtask

    // Unpacks case line n and puts every master's command on its inputs.
    task automatic load_group(input int n, output logic [N_MASTERS-1:0] mask,
                              output logic [N_MASTERS-1:0] late);
        int base;
        mask = cases[n][CASE_W-4 +: N_MASTERS];
        late = cases[n][CASE_W-8 +: N_MASTERS];
        if (mask == '0) begin
            fail_run($sformatf("request group %0d has an empty request mask", n));
        end
        for (int i = 0; i < N_MASTERS; i++) begin
            base        = (N_MASTERS - 1 - i) * FIELD_W; // Master 0 sits leftmost.
            cmd_we[i]   = cases[n][base + ADDR_W + DATA_W];
            cmd_addr[i] = cases[n][base + DATA_W +: ADDR_W];
            cmd_data[i] = cases[n][base +: DATA_W];
            we[i]                     = cmd_we[i];
            addr[i*ADDR_W +: ADDR_W]  = cmd_addr[i];
            wdata[i*DATA_W +: DATA_W] = cmd_data[i];
            acks_seen[i]              = 0;
        end
    endtask

    // Entered in the slot where owner's grant shows. Leaves one slot after its ack.
    task automatic serve_transfer(input logic [N_MASTERS-1:0] owner,
                                  inout logic [N_MASTERS-1:0] pending);
        int idx;
        int cycles;
        idx    = onehot_index(owner);
        cycles = 0;
        do begin
            next_slot();
            cycles++;
            check_value("grant", 32'(owner), 32'(grant)); // Held until ack.
            if (cycles > ACK_LIMIT) begin
                fail_run($sformatf("master %0d got no acknowledge in %0d cycles", idx,
                                   ACK_LIMIT));
            end
        end while (ack !== 1'b1);
        check_value("grant to ack cycles", 32'(LATENCY + 1), 32'(cycles));
        if (cmd_we[idx]) begin
            ref_mem[cmd_addr[idx]] = cmd_data[idx];
        end else begin
            check_value("case file read word", 32'(cmd_data[idx]), 32'(ref_mem[cmd_addr[idx]]));
            check_value("rdata", 32'(ref_mem[cmd_addr[idx]]), 32'(rdata));
        end
        req[idx]     = 1'b0; // Dropped before the edge that ends ack.
        pending[idx] = 1'b0;
        next_slot();
        check_value("ack", 32'd0, 32'(ack)); // One cycle only.
        check_value("grant", 32'(lowest_set(pending)), 32'(grant)); // Next winner or none.
    endtask

    task automatic run_group(input int n);
        logic [N_MASTERS-1:0] mask;
        logic [N_MASTERS-1:0] late;
        logic [N_MASTERS-1:0] pending;
        logic [N_MASTERS-1:0] owner;
        logic [N_MASTERS-1:0] served;
        load_group(n, mask, late);
        pending = mask;
        req     = mask; // Seen at the next edge, arbiter idle.
        next_slot();
        owner = lowest_set(mask);
        check_value("grant", 32'(owner), 32'(grant)); // One cycle after the request.
        check_value("ack", 32'd0, 32'(ack));
        req     = req | late; // Late masters ask while the bus is held.
        pending = pending | late;
        served  = mask | late;
        while (pending != '0) begin
            serve_transfer(owner, pending);
            owner = lowest_set(pending);
        end
        for (int i = 0; i < N_MASTERS; i++) begin
            check_value($sformatf("acks of master %0d", i), 32'(served[i]), 32'(acks_seen[i]));
        end
    endtask

    initial begin : main
        int n;
        int gap;
        int assert_fails;
        clk   = 1'b0;
        reset = 1'b1;
        req   = '0;
        we    = '0;
        addr  = '0;
        wdata = '0;
        for (int i = 0; i < MAX_CASES; i++) begin
            cases[i] = '0; // Zero masks end the list.
        end
        $readmemh("testbench/bus_cases.txt", cases);
        n = 0;
        while (n < MAX_CASES && cases[n][CASE_W-1 -: 8] != 8'h00) begin
            n++;
        end
        if (n == 0) begin
            fail_run("no request groups found in testbench/bus_cases.txt");
        end
        num_cases = n;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        check_value("grant", 32'd0, 32'(grant)); // Reset state.
        check_value("ack", 32'd0, 32'(ack));
        check_idle(IDLE_CYCLES);
        for (int g = 0; g < num_cases; g++) begin
            run_group(g);
            gap = int'({$random(seed)} % 32'd4); // 0 to 3 idle cycles.
            check_idle(gap);
        end
        assert_fails = i_shared_bus_top.i_bus_arbiter.i_shared_bus_properties.fail_count;
        if (assert_fails == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("ERROR: %0d bound assertions failed during the run", assert_fails);
            $display("TB FAILED");
            $fatal(1, "Assertion failures.");
        end
    end

    // Budget grows with the number of groups read.
    initial begin : watchdog
        int budget;
        wait (num_cases > 0);
        budget = (num_cases * N_MASTERS * (LATENCY + 4) + RESET_CYCLES + IDLE_CYCLES + 2)
                 * CLK_PERIOD;
        #(budget);
        $display("ERROR: timeout after %0d ns, the request groups did not finish", budget);
        $display("TB FAILED");
        $fatal(1, "Timeout.");
    end

endmodule

`default_nettype wire
